//--- common/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// datapath and field widths
`define DECODE_NB_DATA    32
`define DECODE_NB_REG     5
`define DECODE_N_REGS     32
`define DECODE_NB_OPCODE  6
`define DECODE_NB_FUNCT   6
`define DECODE_NB_SHAMT   5
`define DECODE_NB_IMM     16
`define DECODE_NB_TARGET  26
`define DECODE_NB_ALU_OP  4

// link register for jal
`define DECODE_JAL_REG    5'd31

// opcode field values
`define DECODE_OP_RTYPE   6'h00
`define DECODE_OP_J       6'h02
`define DECODE_OP_JAL     6'h03
`define DECODE_OP_BEQ     6'h04
`define DECODE_OP_BNE     6'h05
`define DECODE_OP_ADDI    6'h08
`define DECODE_OP_SLTI    6'h0a
`define DECODE_OP_ANDI    6'h0c
`define DECODE_OP_ORI     6'h0d
`define DECODE_OP_XORI    6'h0e
`define DECODE_OP_LUI     6'h0f
`define DECODE_OP_LW      6'h23
`define DECODE_OP_SW      6'h2b

// funct field values, r-type only
`define DECODE_FN_SLL     6'h00
`define DECODE_FN_SRL     6'h02
`define DECODE_FN_ADD     6'h20
`define DECODE_FN_SUB     6'h22
`define DECODE_FN_AND     6'h24
`define DECODE_FN_OR      6'h25
`define DECODE_FN_XOR     6'h26
`define DECODE_FN_SLT     6'h2a

// alu operation codes for the execute stage
// nop for plain jumps, pass_b forwards the lui immediate
`define DECODE_ALU_NOP    4'd0
`define DECODE_ALU_ADD    4'd1
`define DECODE_ALU_SUB    4'd2
`define DECODE_ALU_AND    4'd3
`define DECODE_ALU_OR     4'd4
`define DECODE_ALU_XOR    4'd5
`define DECODE_ALU_SLT    4'd6
`define DECODE_ALU_SLL    4'd7
`define DECODE_ALU_SRL    4'd8
`define DECODE_ALU_PASS_B 4'd9

`endif

//--- common/decode_pkg.sv
`include "decode_settings.svh"

package decode_pkg;

	// plain vectors with a meaning of their own
	typedef logic [`DECODE_NB_DATA-1:0]   word_t;
	typedef logic [`DECODE_NB_DATA-1:0]   instr_t;
	typedef logic [`DECODE_NB_REG-1:0]    reg_addr_t;
	typedef logic [`DECODE_NB_OPCODE-1:0] opcode_t;
	typedef logic [`DECODE_NB_FUNCT-1:0]  funct_t;
	typedef logic [`DECODE_NB_SHAMT-1:0]  shamt_t;
	typedef logic [`DECODE_NB_ALU_OP-1:0] alu_op_t;

	// instruction split into every field
	// imm16 and target26 overlap the r-type fields in the encoding
	typedef struct packed {
		opcode_t                     opcode;
		reg_addr_t                   rs;
		reg_addr_t                   rt;
		reg_addr_t                   rd;
		shamt_t                      shamt;
		funct_t                      funct;
		logic [`DECODE_NB_IMM-1:0]    imm16;
		logic [`DECODE_NB_TARGET-1:0] target26;
	} fields_t;

	// control word consumed by ex, mem and wb
	typedef struct packed {
		alu_op_t alu_op;
		// second operand from the immediate
		logic    alu_src_imm;
		// first operand is shamt
		logic    shift;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    reg_write;
		logic    branch_eq;
		logic    branch_ne;
		logic    jump;
		// write return address to r31
		logic    link;
		logic    illegal;
	} ctrl_t;

	// write-back port into the register bank
	typedef struct packed {
		logic      wr_en;
		reg_addr_t addr;
		word_t     data;
	} wb_t;

	// id/ex pipeline register contents
	typedef struct packed {
		logic                         valid;
		ctrl_t                        ctrl;
		word_t                        data_ra;
		word_t                        data_rb;
		word_t                        imm;
		reg_addr_t                    rs;
		reg_addr_t                    rt;
		reg_addr_t                    dest;
		shamt_t                       shamt;
		logic [`DECODE_NB_TARGET-1:0] target26;
	} id_ex_t;

endpackage

//--- source/instr_fields.sv
`timescale 1ns/10ps
`include "decode_settings.svh"

module instr_fields (
	input  decode_pkg::instr_t    instr_i,
	input  decode_pkg::ctrl_t     ctrl_i,
	output decode_pkg::fields_t   fields_o,
	output decode_pkg::word_t     imm_o,
	output decode_pkg::reg_addr_t dest_o
);

	// fixed mips field positions
	assign fields_o.opcode   = instr_i[31:26];
	assign fields_o.rs       = instr_i[25:21];
	assign fields_o.rt       = instr_i[20:16];
	assign fields_o.rd       = instr_i[15:11];
	assign fields_o.shamt    = instr_i[10:6];
	assign fields_o.funct    = instr_i[5:0];
	// immediate and jump target reuse the low bits
	assign fields_o.imm16    = instr_i[15:0];
	assign fields_o.target26 = instr_i[25:0];

	// immediate extension by opcode class
	always_comb begin
		case (fields_o.opcode)
			// logical immediates take zero extension
			`DECODE_OP_ANDI,
			`DECODE_OP_ORI,
			`DECODE_OP_XORI: begin
				imm_o = {{(`DECODE_NB_DATA-`DECODE_NB_IMM){1'b0}}, fields_o.imm16};
			end
			// lui loads the upper half
			`DECODE_OP_LUI: begin
				imm_o = {fields_o.imm16, {(`DECODE_NB_DATA-`DECODE_NB_IMM){1'b0}}};
			end
			// arithmetic, memory offsets and branch offsets
			default: begin
				imm_o = {{(`DECODE_NB_DATA-`DECODE_NB_IMM){fields_o.imm16[`DECODE_NB_IMM-1]}},
					fields_o.imm16};
			end
		endcase
	end

	// destination register select
	always_comb begin
		if (ctrl_i.link) begin
			// jal writes the return address
			dest_o = `DECODE_JAL_REG;
		end else if (fields_o.opcode == `DECODE_OP_RTYPE) begin
			dest_o = fields_o.rd;
		end else begin
			// i-type writes rt
			dest_o = fields_o.rt;
		end
	end

endmodule

//--- control_unit/control_unit.sv
`timescale 1ns/10ps
`include "decode_settings.svh"

module control_unit (
	input  decode_pkg::opcode_t opcode_i,
	input  decode_pkg::funct_t  funct_i,
	output decode_pkg::ctrl_t   ctrl_o
);

	// unknown encodings collapse to this word
	localparam decode_pkg::ctrl_t CTRL_ILLEGAL = '{illegal: 1'b1, default: '0};

	always_comb begin
		// everything off unless the opcode says otherwise
		ctrl_o = '0;
		case (opcode_i)
			`DECODE_OP_RTYPE: begin
				ctrl_o.reg_write = 1'b1;
				// r-type operation comes from funct
				case (funct_i)
					`DECODE_FN_ADD: begin
						ctrl_o.alu_op = `DECODE_ALU_ADD;
					end
					`DECODE_FN_SUB: begin
						ctrl_o.alu_op = `DECODE_ALU_SUB;
					end
					`DECODE_FN_AND: begin
						ctrl_o.alu_op = `DECODE_ALU_AND;
					end
					`DECODE_FN_OR: begin
						ctrl_o.alu_op = `DECODE_ALU_OR;
					end
					`DECODE_FN_XOR: begin
						ctrl_o.alu_op = `DECODE_ALU_XOR;
					end
					`DECODE_FN_SLT: begin
						ctrl_o.alu_op = `DECODE_ALU_SLT;
					end
					// shifts take shamt as first operand
					`DECODE_FN_SLL: begin
						ctrl_o.alu_op = `DECODE_ALU_SLL;
						ctrl_o.shift  = 1'b1;
					end
					`DECODE_FN_SRL: begin
						ctrl_o.alu_op = `DECODE_ALU_SRL;
						ctrl_o.shift  = 1'b1;
					end
					default: begin
						ctrl_o = CTRL_ILLEGAL;
					end
				endcase
			end
			// immediate alu group
			`DECODE_OP_ADDI: begin
				ctrl_o.alu_op      = `DECODE_ALU_ADD;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.reg_write   = 1'b1;
			end
			`DECODE_OP_ANDI: begin
				ctrl_o.alu_op      = `DECODE_ALU_AND;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.reg_write   = 1'b1;
			end
			`DECODE_OP_ORI: begin
				ctrl_o.alu_op      = `DECODE_ALU_OR;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.reg_write   = 1'b1;
			end
			`DECODE_OP_XORI: begin
				ctrl_o.alu_op      = `DECODE_ALU_XOR;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.reg_write   = 1'b1;
			end
			`DECODE_OP_SLTI: begin
				ctrl_o.alu_op      = `DECODE_ALU_SLT;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.reg_write   = 1'b1;
			end
			// immediate already shifted up, alu just passes it
			`DECODE_OP_LUI: begin
				ctrl_o.alu_op      = `DECODE_ALU_PASS_B;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.reg_write   = 1'b1;
			end
			// address = rs + offset
			`DECODE_OP_LW: begin
				ctrl_o.alu_op      = `DECODE_ALU_ADD;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.mem_read    = 1'b1;
				ctrl_o.mem_to_reg  = 1'b1;
				ctrl_o.reg_write   = 1'b1;
			end
			`DECODE_OP_SW: begin
				ctrl_o.alu_op      = `DECODE_ALU_ADD;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.mem_write   = 1'b1;
			end
			// branches compare by subtraction
			`DECODE_OP_BEQ: begin
				ctrl_o.alu_op    = `DECODE_ALU_SUB;
				ctrl_o.branch_eq = 1'b1;
			end
			`DECODE_OP_BNE: begin
				ctrl_o.alu_op    = `DECODE_ALU_SUB;
				ctrl_o.branch_ne = 1'b1;
			end
			`DECODE_OP_J: begin
				ctrl_o.jump = 1'b1;
			end
			// jal also writes r31
			`DECODE_OP_JAL: begin
				ctrl_o.jump      = 1'b1;
				ctrl_o.link      = 1'b1;
				ctrl_o.reg_write = 1'b1;
			end
			default: begin
				ctrl_o = CTRL_ILLEGAL;
			end
		endcase
	end

endmodule

//--- register_bank/register_bank.sv
`timescale 1ns/10ps
`include "decode_settings.svh"

module register_bank (
	input  logic                  clock_i,
	input  logic                  rst_n_i,
	input  decode_pkg::reg_addr_t addr_ra_i,
	input  decode_pkg::reg_addr_t addr_rb_i,
	input  decode_pkg::wb_t       wb_i,
	output decode_pkg::word_t     data_ra_o,
	output decode_pkg::word_t     data_rb_o
);

	// r0 has no storage
	decode_pkg::word_t regs [1:`DECODE_N_REGS-1];

	// one read port with write-through
	function automatic decode_pkg::word_t read_port(
		input decode_pkg::reg_addr_t addr
	);
		decode_pkg::word_t data;
		if (addr == '0) begin
			// r0 is hard zero
			data = '0;
		end else if (wb_i.wr_en && (wb_i.addr == addr)) begin
			// same-cycle write wins over stored value
			data = wb_i.data;
		end else begin
			data = regs[addr];
		end
		return data;
	endfunction

	// write port, clears the whole bank on reset
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < `DECODE_N_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.wr_en && (wb_i.addr != '0)) begin
			// writes to r0 dropped
			regs[wb_i.addr] <= wb_i.data;
		end
	end

	// combinational reads, follow the bank and the write port too
	always_comb begin
		data_ra_o = read_port(addr_ra_i);
		data_rb_o = read_port(addr_rb_i);
	end

endmodule

//--- source/decode_top.sv
`timescale 1ns/10ps

module decode_top (
	input  logic                clock_i,
	input  logic                rst_n_i,
	input  logic                valid_i,
	input  decode_pkg::instr_t  instr_i,
	input  logic                stall_i,
	input  decode_pkg::wb_t     wb_i,
	output decode_pkg::id_ex_t  id_ex_o
);

	// decode results for the current instruction
	decode_pkg::fields_t   fields;
	decode_pkg::ctrl_t     ctrl;
	decode_pkg::word_t     imm;
	decode_pkg::reg_addr_t dest;
	decode_pkg::word_t     data_ra;
	decode_pkg::word_t     data_rb;

	// next id/ex value
	decode_pkg::id_ex_t    id_ex_next;

	// id/ex control part, reset
	logic                  valid_q;
	decode_pkg::ctrl_t     ctrl_q;

	// id/ex payload part
	decode_pkg::id_ex_t    payload_q;

	instr_fields instr_fields_inst (
		.instr_i  (instr_i),
		.ctrl_i   (ctrl),
		.fields_o (fields),
		.imm_o    (imm),
		.dest_o   (dest)
	);

	control_unit control_unit_inst (
		.opcode_i (fields.opcode),
		.funct_i  (fields.funct),
		.ctrl_o   (ctrl)
	);

	register_bank register_bank_inst (
		.clock_i   (clock_i),
		.rst_n_i   (rst_n_i),
		.addr_ra_i (fields.rs),
		.addr_rb_i (fields.rt),
		.wb_i      (wb_i),
		.data_ra_o (data_ra),
		.data_rb_o (data_rb)
	);

	// gather everything the execute stage needs
	always_comb begin
		id_ex_next          = '0;
		id_ex_next.valid    = valid_i;
		id_ex_next.ctrl     = ctrl;
		id_ex_next.data_ra  = data_ra;
		id_ex_next.data_rb  = data_rb;
		id_ex_next.imm      = imm;
		id_ex_next.rs       = fields.rs;
		id_ex_next.rt       = fields.rt;
		id_ex_next.dest     = dest;
		id_ex_next.shamt    = fields.shamt;
		id_ex_next.target26 = fields.target26;
	end

	// valid and control, hold on stall
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
			ctrl_q  <= '0;
		end else if (!stall_i) begin
			valid_q <= valid_i;
			// bubble when nothing valid arrives
			ctrl_q  <= valid_i ? id_ex_next.ctrl : '0;
		end
	end

	// payload only moves when not stalled
	always_ff @(posedge clock_i) begin
		if (!stall_i) begin
			payload_q <= id_ex_next;
		end
	end

	// control fields from the reset register, rest from payload
	always_comb begin
		id_ex_o       = payload_q;
		id_ex_o.valid = valid_q;
		id_ex_o.ctrl  = ctrl_q;
	end

endmodule

//--- verification/decode_chk.sv
`timescale 1ns/10ps
`include "decode_settings.svh"

module decode_chk (
	input logic               clock_i,
	input logic               rst_n_i,
	input logic               stall_i,
	input decode_pkg::id_ex_t id_ex_i
);

	int assert_fails = 0;

	// nothing valid in the first cycle after reset
	assert property (@(posedge clock_i) !rst_n_i |=> !id_ex_i.valid)
		else begin
			$error("id/ex valid set right after reset");
			assert_fails++;
		end

	// a stalled edge leaves id/ex unchanged
	assert property (@(posedge clock_i) disable iff (!rst_n_i)
		stall_i |=> $stable(id_ex_i))
		else begin
			$error("id/ex changed across a stalled edge");
			assert_fails++;
		end

	// bubbles carry no control
	assert property (@(posedge clock_i) disable iff (!rst_n_i)
		!id_ex_i.valid |-> (id_ex_i.ctrl == '0))
		else begin
			$error("control bits set while id/ex is not valid");
			assert_fails++;
		end

	// link writes go to r31
	assert property (@(posedge clock_i) disable iff (!rst_n_i)
		(id_ex_i.ctrl.reg_write && id_ex_i.ctrl.link) |-> (id_ex_i.dest == `DECODE_JAL_REG))
		else begin
			$error("link write with destination other than r31");
			assert_fails++;
		end

endmodule

bind decode_top decode_chk decode_chk_inst (
	.clock_i (clock_i),
	.rst_n_i (rst_n_i),
	.stall_i (stall_i),
	.id_ex_i (id_ex_o)
);

//--- verification/decode_tb.sv
`timescale 1ns/10ps
`include "decode_settings.svh"

module decode_tb;

	localparam int RESET_CYCLES = 3;
	// test lengths in cycles
	localparam int LEN_REGS  = 80;
	localparam int LEN_CTRL  = 120;
	localparam int LEN_IMM   = 60;
	localparam int LEN_DEST  = 60;
	localparam int LEN_STALL = 120;
	localparam int LEN_WT    = 60;
	localparam int TIMEOUT   = (RESET_CYCLES + 1 + LEN_REGS + LEN_CTRL + LEN_IMM + LEN_DEST
		+ LEN_STALL + LEN_WT) * 3 / 2;

	logic               clock;
	logic               rst_n;
	logic               valid;
	logic               stall;
	decode_pkg::instr_t instr;
	decode_pkg::wb_t    wb;
	decode_pkg::id_ex_t id_ex;

	// reference model state
	decode_pkg::word_t  model_regs [0:`DECODE_N_REGS-1];
	decode_pkg::id_ex_t expected;
	logic [31:0]        lfsr;
	int                 cycle_count = 0;
	int                 error_count = 0;
	int                 check_count = 0;
	int                 test_count = 0;

	decode_top decode_top_inst (
		.clock_i (clock),
		.rst_n_i (rst_n),
		.valid_i (valid),
		.instr_i (instr),
		.stall_i (stall),
		.wb_i    (wb),
		.id_ex_o (id_ex)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// hard limit on run length
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT) begin
			$display("timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("Something failed");
			$finish;
		end
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	// 0..12 supported, anything above random and mostly illegal
	function automatic decode_pkg::opcode_t pick_opcode(input int idx);
		decode_pkg::opcode_t op;
		case (idx)
			0: op = `DECODE_OP_RTYPE;
			1: op = `DECODE_OP_J;
			2: op = `DECODE_OP_JAL;
			3: op = `DECODE_OP_ADDI;
			4: op = `DECODE_OP_ANDI;
			5: op = `DECODE_OP_ORI;
			6: op = `DECODE_OP_XORI;
			7: op = `DECODE_OP_SLTI;
			8: op = `DECODE_OP_LUI;
			9: op = `DECODE_OP_LW;
			10: op = `DECODE_OP_SW;
			11: op = `DECODE_OP_BEQ;
			12: op = `DECODE_OP_BNE;
			default: op = take_bits(6);
		endcase
		return op;
	endfunction

	function automatic decode_pkg::funct_t pick_funct();
		decode_pkg::funct_t fn;
		case (take_bits(3))
			0: fn = `DECODE_FN_ADD;
			1: fn = `DECODE_FN_SUB;
			2: fn = `DECODE_FN_AND;
			3: fn = `DECODE_FN_OR;
			4: fn = `DECODE_FN_XOR;
			5: fn = `DECODE_FN_SLL;
			6: fn = `DECODE_FN_SRL;
			default: fn = `DECODE_FN_SLT;
		endcase
		return fn;
	endfunction

	// expected control word per encoding
	// row bits: src_imm shift mem_read mem_write mem_to_reg reg_write beq bne jump link
	function automatic decode_pkg::ctrl_t ctrl_table(
		input decode_pkg::opcode_t op,
		input decode_pkg::funct_t  fn
	);
		logic [14:0] row;
		// illegal unless matched below
		row = 15'h0001;
		case (op)
			`DECODE_OP_RTYPE: begin
				case (fn)
					`DECODE_FN_ADD: row = {`DECODE_ALU_ADD, 10'b0_0_0_0_0_1_0_0_0_0, 1'b0};
					`DECODE_FN_SUB: row = {`DECODE_ALU_SUB, 10'b0_0_0_0_0_1_0_0_0_0, 1'b0};
					`DECODE_FN_AND: row = {`DECODE_ALU_AND, 10'b0_0_0_0_0_1_0_0_0_0, 1'b0};
					`DECODE_FN_OR:  row = {`DECODE_ALU_OR,  10'b0_0_0_0_0_1_0_0_0_0, 1'b0};
					`DECODE_FN_XOR: row = {`DECODE_ALU_XOR, 10'b0_0_0_0_0_1_0_0_0_0, 1'b0};
					`DECODE_FN_SLT: row = {`DECODE_ALU_SLT, 10'b0_0_0_0_0_1_0_0_0_0, 1'b0};
					`DECODE_FN_SLL: row = {`DECODE_ALU_SLL, 10'b0_1_0_0_0_1_0_0_0_0, 1'b0};
					`DECODE_FN_SRL: row = {`DECODE_ALU_SRL, 10'b0_1_0_0_0_1_0_0_0_0, 1'b0};
					default: row = 15'h0001;
				endcase
			end
			`DECODE_OP_ADDI: row = {`DECODE_ALU_ADD,    10'b1_0_0_0_0_1_0_0_0_0, 1'b0};
			`DECODE_OP_ANDI: row = {`DECODE_ALU_AND,    10'b1_0_0_0_0_1_0_0_0_0, 1'b0};
			`DECODE_OP_ORI:  row = {`DECODE_ALU_OR,     10'b1_0_0_0_0_1_0_0_0_0, 1'b0};
			`DECODE_OP_XORI: row = {`DECODE_ALU_XOR,    10'b1_0_0_0_0_1_0_0_0_0, 1'b0};
			`DECODE_OP_SLTI: row = {`DECODE_ALU_SLT,    10'b1_0_0_0_0_1_0_0_0_0, 1'b0};
			`DECODE_OP_LUI:  row = {`DECODE_ALU_PASS_B, 10'b1_0_0_0_0_1_0_0_0_0, 1'b0};
			`DECODE_OP_LW:   row = {`DECODE_ALU_ADD,    10'b1_0_1_0_1_1_0_0_0_0, 1'b0};
			`DECODE_OP_SW:   row = {`DECODE_ALU_ADD,    10'b1_0_0_1_0_0_0_0_0_0, 1'b0};
			`DECODE_OP_BEQ:  row = {`DECODE_ALU_SUB,    10'b0_0_0_0_0_0_1_0_0_0, 1'b0};
			`DECODE_OP_BNE:  row = {`DECODE_ALU_SUB,    10'b0_0_0_0_0_0_0_1_0_0, 1'b0};
			`DECODE_OP_J:    row = {`DECODE_ALU_NOP,    10'b0_0_0_0_0_0_0_0_1_0, 1'b0};
			`DECODE_OP_JAL:  row = {`DECODE_ALU_NOP,    10'b0_0_0_0_0_1_0_0_1_1, 1'b0};
			default: row = 15'h0001;
		endcase
		return row;
	endfunction

	// model register read, same-cycle write-back wins
	function automatic decode_pkg::word_t read_model_reg(input decode_pkg::reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end
		if (wb.wr_en && wb.addr == addr) begin
			return wb.data;
		end
		return model_regs[addr];
	endfunction

	// id/ex value expected after the next unstalled edge
	function automatic decode_pkg::id_ex_t predict_id_ex();
		decode_pkg::id_ex_t  p;
		decode_pkg::opcode_t op;
		logic [15:0]         imm16;
		op         = instr[31:26];
		imm16      = instr[15:0];
		p          = '0;
		p.valid    = valid;
		p.ctrl     = valid ? ctrl_table(op, instr[5:0]) : '0;
		p.rs       = instr[25:21];
		p.rt       = instr[20:16];
		p.shamt    = instr[10:6];
		p.target26 = instr[25:0];
		p.data_ra  = read_model_reg(p.rs);
		p.data_rb  = read_model_reg(p.rt);
		case (op)
			`DECODE_OP_ANDI, `DECODE_OP_ORI, `DECODE_OP_XORI: p.imm = {16'h0000, imm16};
			`DECODE_OP_LUI: p.imm = {imm16, 16'h0000};
			default: p.imm = {{16{imm16[15]}}, imm16};
		endcase
		if (op == `DECODE_OP_JAL) begin
			p.dest = 5'd31;
		end else if (op == `DECODE_OP_RTYPE) begin
			p.dest = instr[15:11];
		end else begin
			p.dest = instr[20:16];
		end
		return p;
	endfunction

	task automatic check_ctrl(input string name, input decode_pkg::ctrl_t exp,
		input decode_pkg::ctrl_t got);
		check_count++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
			error_count++;
		end
	endtask

	task automatic check_word(input string name, input decode_pkg::word_t exp,
		input decode_pkg::word_t got);
		check_count++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
			error_count++;
		end
	endtask

	task automatic check_reg(input string name, input decode_pkg::reg_addr_t exp,
		input decode_pkg::reg_addr_t got);
		check_count++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, got);
			error_count++;
		end
	endtask

	task automatic check_shamt(input string name, input decode_pkg::shamt_t exp,
		input decode_pkg::shamt_t got);
		check_count++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, got);
			error_count++;
		end
	endtask

	task automatic check_target(input string name, input logic [`DECODE_NB_TARGET-1:0] exp,
		input logic [`DECODE_NB_TARGET-1:0] got);
		check_count++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		check_count++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, got);
			error_count++;
		end
	endtask

	// payload only matters for a valid entry
	task automatic compare_id_ex();
		check_flag("id_ex_o.valid", expected.valid, id_ex.valid);
		check_ctrl("id_ex_o.ctrl", expected.ctrl, id_ex.ctrl);
		if (expected.valid) begin
			check_word("id_ex_o.data_ra", expected.data_ra, id_ex.data_ra);
			check_word("id_ex_o.data_rb", expected.data_rb, id_ex.data_rb);
			check_word("id_ex_o.imm", expected.imm, id_ex.imm);
			check_reg("id_ex_o.rs", expected.rs, id_ex.rs);
			check_reg("id_ex_o.rt", expected.rt, id_ex.rt);
			check_reg("id_ex_o.dest", expected.dest, id_ex.dest);
			check_shamt("id_ex_o.shamt", expected.shamt, id_ex.shamt);
			check_target("id_ex_o.target26", expected.target26, id_ex.target26);
		end
	endtask

	// modes 0 regs, 1 ctrl, 2 imm, 3 dest, 4 stall, 5 write-through
	task automatic make_stimulus(input int mode);
		decode_pkg::opcode_t op;
		decode_pkg::funct_t  fn;
		logic [19:0]         mid;
		wb.wr_en = take_bits(1);
		wb.addr  = take_bits(5);
		wb.data  = take_bits(32);
		stall    = 1'b0;
		if (mode == 4) begin
			stall = take_bits(1);
			// fetch holds its instruction and valid while stalled
			if (stall) begin
				return;
			end
			valid = take_bits(1);
		end else begin
			valid = 1'b1;
		end
		fn  = pick_funct();
		mid = take_bits(20);
		case (mode)
			0: op = `DECODE_OP_RTYPE;
			// only opcodes that carry an immediate
			2: op = pick_opcode(3 + take_bits(4) % 10);
			default: op = pick_opcode(take_bits(4));
		endcase
		if (mode == 1 && take_bits(2) == 0) begin
			fn = take_bits(6);
		end
		instr = {op, mid, fn};
		if (mode == 0) begin
			wb.wr_en = 1'b1;
			// r0 writes and reads now and then
			if (take_bits(3) == 0) wb.addr = '0;
			if (take_bits(3) == 0) instr[25:21] = '0;
		end
		if (mode == 5) begin
			wb.wr_en = 1'b1;
			wb.addr  = take_bits(1) ? instr[25:21] : instr[20:16];
		end
	endtask

	task automatic run_test(input int mode, input int len, input string name);
		decode_pkg::id_ex_t next_exp;
		int                 errors_before;
		int                 c;
		errors_before = error_count;
		for (c = 0; c < len; c++) begin
			make_stimulus(mode);
			next_exp = stall ? expected : predict_id_ex();
			@(posedge clock);
			// write-back lands at this edge
			if (wb.wr_en && wb.addr != '0) model_regs[wb.addr] = wb.data;
			expected = next_exp;
			#1;
			compare_id_ex();
		end
		test_count++;
		$display("test %-16s %0d cycles, %0d errors", name, len, error_count - errors_before);
	endtask

	initial begin
		rst_n      = 1'b0;
		valid      = 1'b0;
		stall      = 1'b0;
		instr      = '0;
		wb         = '0;
		lfsr       = 32'h4d4f_f555;
		expected   = '0;
		model_regs = '{default: '0};
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		rst_n = 1'b1;
		// state straight out of reset
		compare_id_ex();
		run_test(0, LEN_REGS, "regs_write_read");
		run_test(1, LEN_CTRL, "control_decode");
		run_test(2, LEN_IMM, "imm_extension");
		run_test(3, LEN_DEST, "dest_select");
		run_test(4, LEN_STALL, "stall_bubble");
		run_test(5, LEN_WT, "write_through");
		error_count += decode_top_inst.decode_chk_inst.assert_fails;
		$display("%0d tests, %0d checks, %0d assertion failures, %0d errors total",
			test_count, check_count, decode_top_inst.decode_chk_inst.assert_fails, error_count);
		if (error_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+common
common/decode_pkg.sv
source/instr_fields.sv
control_unit/control_unit.sv
register_bank/register_bank.sv
source/decode_top.sv
verification/decode_chk.sv
verification/decode_tb.sv

//--- Bender.yml
package:
  name: decode

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/decode_pkg.sv
      - source/instr_fields.sv
      - control_unit/control_unit.sv
      - register_bank/register_bank.sv
      - source/decode_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/decode_chk.sv
      - verification/decode_tb.sv
